/* source/bft_pkg.sv */
// Offload package with beat, header and statistics types plus FSM encodings
package bft_pkg;

    // Beat geometry
    localparam int data_bits = 64;
    localparam int keep_bits = data_bits / 8;

    // Width of every statistics and run counter
    localparam int stat_bits = 32;

    typedef struct packed {
        logic [data_bits-1:0] data;
        logic [keep_bits-1:0] keep;
        logic                 last;
    } bft_beat_t;

    // Anything besides these two is dropped at the steering stage
    typedef enum logic [7:0] {
        op_net  = 8'd1,
        op_auth = 8'd2
    } bft_op_t;

    // Carried in the data field of the first beat of a message
    typedef struct packed {
        bft_op_t     op;
        logic [15:0] seq;
        logic [39:0] rsvd;
    } bft_hdr_t;

    typedef struct packed {
        logic [stat_bits-1:0] bytes;
        logic [stat_bits-1:0] msgs;
        logic [stat_bits-1:0] stalls;
    } bft_path_stat_t;

    typedef enum logic [1:0] {
        st_hdr,
        st_net,
        st_auth,
        st_drop
    } steer_state_t;

    typedef enum logic [1:0] {
        mg_idle,
        mg_net,
        mg_auth
    } merge_state_t;

    typedef enum logic {
        tg_pass,
        tg_tag
    } tag_state_t;

endpackage

/* source/bft_steer.sv */
// Message steering that routes each message to the network or authentication path by opcode
module bft_steer import bft_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      in_valid,
    output logic      in_ready,
    input  bft_beat_t in_beat,

    output logic      net_valid,
    input  logic      net_ready,
    output bft_beat_t net_beat,

    output logic      auth_valid,
    input  logic      auth_ready,
    output bft_beat_t auth_beat
);

    steer_state_t state;
    bft_hdr_t     hdr;
    logic         in_fire;

    // Header view of the current beat, only meaningful in st_hdr
    assign hdr = bft_hdr_t'(in_beat.data);

    // Both paths see the same beat, valid picks the one that takes it
    assign net_beat  = in_beat;
    assign auth_beat = in_beat;

    assign in_fire = in_valid && in_ready;

    always_comb begin
        net_valid  = 1'b0;
        auth_valid = 1'b0;
        in_ready   = 1'b0;
        case (state)
            st_hdr: begin
                case (hdr.op)
                    op_net: begin
                        net_valid = in_valid;
                        in_ready  = net_ready;
                    end
                    op_auth: begin
                        auth_valid = in_valid;
                        in_ready   = auth_ready;
                    end
                    // Unknown opcode, swallow the header
                    default: in_ready = 1'b1;
                endcase
            end
            st_net: begin
                net_valid = in_valid;
                in_ready  = net_ready;
            end
            st_auth: begin
                auth_valid = in_valid;
                in_ready   = auth_ready;
            end
            default: in_ready = 1'b1;
        endcase
    end

    // Route lock, released by the last beat of the message
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= st_hdr;
        end else if (in_fire) begin
            if (in_beat.last) begin
                state <= st_hdr;
            end else if (state == st_hdr) begin
                case (hdr.op)
                    op_net:  state <= st_net;
                    op_auth: state <= st_auth;
                    default: state <= st_drop;
                endcase
            end
        end
    end

endmodule

/* source/bft_path_profiler.sv */
// Path profiler, a one-deep register stage that counts bytes, messages and stall cycles
module bft_path_profiler import bft_pkg::*; (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           clear_stats,

    input  logic           s_valid,
    output logic           s_ready,
    input  bft_beat_t      s_beat,

    output logic           m_valid,
    input  logic           m_ready,
    output bft_beat_t      m_beat,

    output bft_path_stat_t stat
);

    logic      full;
    bft_beat_t beat_q;
    logic [$clog2(keep_bits+1)-1:0] keep_cnt;
    logic      m_fire;

    assign m_valid = full;
    assign m_beat  = beat_q;

    // Accept when empty or when the held beat leaves this cycle
    assign s_ready = !full || m_ready;
    assign m_fire  = full && m_ready;

    // Number of valid bytes in the outgoing beat
    always_comb begin
        keep_cnt = '0;
        for (int i = 0; i < keep_bits; i++) begin
            keep_cnt = keep_cnt + beat_q.keep[i];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (s_valid && s_ready) begin
            full <= 1'b1;
        end else if (m_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            beat_q <= s_beat;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || clear_stats) begin
            stat <= '0;
        end else begin
            if (m_fire) begin
                stat.bytes <= stat.bytes + stat_bits'(keep_cnt);
                if (beat_q.last) begin
                    stat.msgs <= stat.msgs + 1'b1;
                end
            end
            // Beat held but downstream not taking it
            if (full && !m_ready) begin
                stat.stalls <= stat.stalls + 1'b1;
            end
        end
    end

endmodule

/* source/bft_auth_tagger.sv */
// Authentication tagger that forwards the message and appends an XOR tag beat
module bft_auth_tagger import bft_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      s_valid,
    output logic      s_ready,
    input  bft_beat_t s_beat,

    output logic      m_valid,
    input  logic      m_ready,
    output bft_beat_t m_beat
);

    tag_state_t           state;
    logic                 out_full;
    bft_beat_t            out_q;
    logic                 at_hdr;
    logic [data_bits-1:0] tag_acc;
    logic                 load_ok;
    logic                 s_fire;
    logic                 tag_load;

    assign m_valid = out_full;
    assign m_beat  = out_q;

    // Output register can take a new beat
    assign load_ok  = !out_full || m_ready;
    assign s_ready  = (state == tg_pass) && load_ok;
    assign s_fire   = s_valid && s_ready;
    assign tag_load = (state == tg_tag) && load_ok;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= tg_pass;
            out_full <= 1'b0;
            at_hdr   <= 1'b1;
        end else begin
            case (state)
                tg_pass: begin
                    if (s_fire) begin
                        out_full <= 1'b1;
                        at_hdr   <= 1'b0;
                        if (s_beat.last) begin
                            state <= tg_tag;
                        end
                    end else if (m_ready) begin
                        out_full <= 1'b0;
                    end
                end
                default: begin
                    // Tag beat goes out once the register frees up
                    if (tag_load) begin
                        out_full <= 1'b1;
                        at_hdr   <= 1'b1;
                        state    <= tg_pass;
                    end
                end
            endcase
        end
    end

    // Data path, last moves from the final input beat onto the tag
    always_ff @(posedge aclk) begin
        if (s_fire) begin
            out_q.data <= s_beat.data;
            out_q.keep <= s_beat.keep;
            out_q.last <= 1'b0;
        end else if (tag_load) begin
            out_q.data <= tag_acc;
            out_q.keep <= '1;
            out_q.last <= 1'b1;
        end
    end

    // XOR over everything after the header
    always_ff @(posedge aclk) begin
        if (s_fire) begin
            if (at_hdr) begin
                tag_acc <= '0;
            end else begin
                tag_acc <= tag_acc ^ s_beat.data;
            end
        end
    end

endmodule

/* source/bft_merge.sv */
// Round-robin merge of the network and authentication paths, locked per message
module bft_merge import bft_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      net_valid,
    output logic      net_ready,
    input  bft_beat_t net_beat,

    input  logic      auth_valid,
    output logic      auth_ready,
    input  bft_beat_t auth_beat,

    output logic      m_valid,
    input  logic      m_ready,
    output bft_beat_t m_beat
);

    merge_state_t state;
    logic         last_auth;
    logic         sel_auth;
    logic         m_fire;

    // Grant choice, fixed while a message is in flight
    always_comb begin
        case (state)
            mg_net:  sel_auth = 1'b0;
            mg_auth: sel_auth = 1'b1;
            default: begin
                if (net_valid && auth_valid) begin
                    sel_auth = !last_auth;
                end else begin
                    sel_auth = auth_valid;
                end
            end
        endcase
    end

    assign m_valid    = sel_auth ? auth_valid : net_valid;
    assign m_beat     = sel_auth ? auth_beat : net_beat;
    assign net_ready  = !sel_auth && m_ready;
    assign auth_ready = sel_auth && m_ready;
    assign m_fire     = m_valid && m_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= mg_idle;
            last_auth <= 1'b0;
        end else if (m_fire) begin
            last_auth <= sel_auth;
            if (m_beat.last) begin
                state <= mg_idle;
            end else begin
                state <= sel_auth ? mg_auth : mg_net;
            end
        end
    end

endmodule

/* source/bft_run_ctrl.sv */
// Run control with start edge detect, cycle counter, output message count and done flag
module bft_run_ctrl import bft_pkg::*; (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 ap_start,
    input  logic [stat_bits-1:0] exp_msgs,

    input  logic                 out_valid,
    input  logic                 out_ready,
    input  logic                 out_last,

    output logic                 clear_stats,
    output logic                 ap_done,
    output logic [stat_bits-1:0] execution_cycles
);

    logic                 ap_start_q;
    logic                 start_pulse;
    logic                 running;
    logic [stat_bits-1:0] msg_cnt;

    // Rising edge of the start level
    assign start_pulse = ap_start && !ap_start_q;
    assign clear_stats = start_pulse;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ap_start_q <= 1'b0;
        end else begin
            ap_start_q <= ap_start;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            running          <= 1'b0;
            ap_done          <= 1'b0;
            execution_cycles <= '0;
            msg_cnt          <= '0;
        end else if (start_pulse) begin
            running          <= 1'b1;
            ap_done          <= 1'b0;
            execution_cycles <= '0;
            msg_cnt          <= '0;
        end else if (running) begin
            execution_cycles <= execution_cycles + 1'b1;
            if (out_valid && out_ready && out_last) begin
                msg_cnt <= msg_cnt + 1'b1;
            end
            // Expected count reached, freeze until the next start
            if ((exp_msgs != '0) && (msg_cnt == exp_msgs)) begin
                ap_done <= 1'b1;
                running <= 1'b0;
            end
        end
    end

endmodule

/* source/bft_offload_top.sv */
// Transmit offload top joining steering, both profiled paths, the merge and run control
module bft_offload_top import bft_pkg::*; (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  bft_beat_t            in_beat,

    output logic                 out_valid,
    input  logic                 out_ready,
    output bft_beat_t            out_beat,

    output bft_path_stat_t       net_stat,
    output bft_path_stat_t       auth_stat,

    input  logic                 ap_start,
    input  logic [stat_bits-1:0] exp_msgs,
    output logic                 ap_done,
    output logic [stat_bits-1:0] execution_cycles
);

    // Steering to path profilers
    logic      net_s_valid, net_s_ready;
    bft_beat_t net_s_beat;
    logic      auth_s_valid, auth_s_ready;
    bft_beat_t auth_s_beat;

    // Profiler outputs
    logic      net_m_valid, net_m_ready;
    bft_beat_t net_m_beat;
    logic      auth_p_valid, auth_p_ready;
    bft_beat_t auth_p_beat;

    // Tagger to merge
    logic      auth_m_valid, auth_m_ready;
    bft_beat_t auth_m_beat;

    logic      clear_stats;

    bft_steer bft_steer_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .net_valid  (net_s_valid),
        .net_ready  (net_s_ready),
        .net_beat   (net_s_beat),
        .auth_valid (auth_s_valid),
        .auth_ready (auth_s_ready),
        .auth_beat  (auth_s_beat)
    );

    bft_path_profiler net_profiler_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .clear_stats (clear_stats),
        .s_valid     (net_s_valid),
        .s_ready     (net_s_ready),
        .s_beat      (net_s_beat),
        .m_valid     (net_m_valid),
        .m_ready     (net_m_ready),
        .m_beat      (net_m_beat),
        .stat        (net_stat)
    );

    bft_path_profiler auth_profiler_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .clear_stats (clear_stats),
        .s_valid     (auth_s_valid),
        .s_ready     (auth_s_ready),
        .s_beat      (auth_s_beat),
        .m_valid     (auth_p_valid),
        .m_ready     (auth_p_ready),
        .m_beat      (auth_p_beat),
        .stat        (auth_stat)
    );

    bft_auth_tagger bft_auth_tagger_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (auth_p_valid),
        .s_ready (auth_p_ready),
        .s_beat  (auth_p_beat),
        .m_valid (auth_m_valid),
        .m_ready (auth_m_ready),
        .m_beat  (auth_m_beat)
    );

    bft_merge bft_merge_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .net_valid  (net_m_valid),
        .net_ready  (net_m_ready),
        .net_beat   (net_m_beat),
        .auth_valid (auth_m_valid),
        .auth_ready (auth_m_ready),
        .auth_beat  (auth_m_beat),
        .m_valid    (out_valid),
        .m_ready    (out_ready),
        .m_beat     (out_beat)
    );

    bft_run_ctrl bft_run_ctrl_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .ap_start         (ap_start),
        .exp_msgs         (exp_msgs),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_last         (out_beat.last),
        .clear_stats      (clear_stats),
        .ap_done          (ap_done),
        .execution_cycles (execution_cycles)
    );

endmodule

/* verification/bft_offload_tb.sv */
// Directed testbench for the transmit offload top with a message level reference model
module bft_offload_tb import bft_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 2000;
    localparam int watchdog_ns    = 2000000;

    logic                 aclk = 1'b0;
    logic                 aresetn;
    logic                 in_valid;
    logic                 in_ready;
    bft_beat_t            in_beat;
    logic                 out_valid;
    logic                 out_ready;
    bft_beat_t            out_beat;
    bft_path_stat_t       net_stat;
    bft_path_stat_t       auth_stat;
    logic                 ap_start;
    logic [stat_bits-1:0] exp_msgs;
    logic                 ap_done;
    logic [stat_bits-1:0] execution_cycles;

    integer seed       = 32'hf42;
    int     check_errs = 0;
    int     other_errs = 0;
    logic   bp_on      = 1'b0;

    // Reference model, expected beats indexed by the low seq bits
    bft_beat_t            stim_q[$];
    bft_beat_t            exp_beats[$];
    int                   exp_start[256];
    int                   exp_len[256];
    bit                   exp_live[256];
    int                   exp_count;
    int                   next_seq = 0;
    logic [stat_bits-1:0] net_bytes;
    logic [stat_bits-1:0] net_msgs;
    logic [stat_bits-1:0] auth_bytes;
    logic [stat_bits-1:0] auth_msgs;

    // Output capture
    bft_beat_t rx_q[$];
    int        rx_last = 0;
    int        rx_mark;
    int        last_mark;

    bft_offload_top bft_offload_top_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_beat          (in_beat),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_beat         (out_beat),
        .net_stat         (net_stat),
        .auth_stat        (auth_stat),
        .ap_start         (ap_start),
        .exp_msgs         (exp_msgs),
        .ap_done          (ap_done),
        .execution_cycles (execution_cycles)
    );

    always #10 aclk = ~aclk;

    // Sink ready, random only while back-pressure is enabled
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge aclk);
            out_ready = bp_on ? 1'($random(seed)) : 1'b1;
        end
    end

    always @(posedge aclk) begin
        if (aresetn && out_valid && out_ready) begin
            rx_q.push_back(out_beat);
            if (out_beat.last) begin
                rx_last++;
            end
        end
    end

    task automatic check_beat(input string name, input bft_beat_t exp, input bft_beat_t act);
        if (act !== exp) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %h/%h/%b, actual %h/%h/%b",
                     name, exp.data, exp.keep, exp.last, act.data, act.keep, act.last);
        end
    endtask

    task automatic check_stat(input string name, input bft_path_stat_t exp,
                              input bft_path_stat_t act);
        if (act !== exp) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %0d/%0d/%0d, actual %0d/%0d/%0d", name,
                     exp.bytes, exp.msgs, exp.stalls, act.bytes, act.msgs, act.stalls);
        end
    endtask

    task automatic check_count(input string name, input logic [stat_bits-1:0] exp,
                               input logic [stat_bits-1:0] act);
        if (act !== exp) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge aclk);
    endtask

    // Header plus payload, expected output and statistics per message
    task automatic build_msg(input logic [7:0] op, input int n_pay);
        bft_hdr_t             hdr;
        bft_beat_t            b;
        logic [data_bits-1:0] tag;
        logic [31:0]          r;
        int                   nk;
        int                   bytes;
        int                   k;
        hdr.op   = bft_op_t'(op);
        hdr.seq  = 16'(next_seq);
        hdr.rsvd = {8'h00, 32'($random(seed))};
        k        = next_seq % 256;
        next_seq++;
        b.data = hdr;
        b.keep = '1;
        b.last = 1'b0;
        stim_q.push_back(b);
        exp_start[k] = exp_beats.size();
        exp_beats.push_back(b);
        tag   = '0;
        bytes = keep_bits;
        for (int i = 0; i < n_pay; i++) begin
            b.data = {32'($random(seed)), 32'($random(seed))};
            nk     = keep_bits;
            // Final beat carries a partial keep
            if (i == n_pay - 1) begin
                r  = $random(seed);
                nk = 1 + int'(r[2:0]);
            end
            b.keep = '1;
            b.keep = b.keep >> (keep_bits - nk);
            b.last = (i == n_pay - 1);
            bytes += nk;
            tag ^= b.data;
            stim_q.push_back(b);
            if (op == op_auth) begin
                b.last = 1'b0;
            end
            exp_beats.push_back(b);
        end
        if (op == op_auth) begin
            b.data = tag;
            b.keep = '1;
            b.last = 1'b1;
            exp_beats.push_back(b);
        end
        exp_len[k]  = exp_beats.size() - exp_start[k];
        exp_live[k] = (op == op_net) || (op == op_auth);
        if (op == op_net) begin
            net_bytes += stat_bits'(bytes);
            net_msgs  += 1;
            exp_count++;
        end else if (op == op_auth) begin
            auth_bytes += stat_bits'(bytes);
            auth_msgs  += 1;
            exp_count++;
        end
    endtask

    task automatic add_random_msgs(input int n, input bit allow_invalid);
        logic [31:0] r;
        logic [7:0]  op;
        for (int i = 0; i < n; i++) begin
            r  = $random(seed);
            op = r[3] ? op_auth : op_net;
            if (allow_invalid && (r[6:4] == 3'd7)) begin
                op = 8'h5a;
            end
            build_msg(op, 1 + int'(r[1:0]));
        end
    endtask

    task automatic drive_all(input string name);
        bft_beat_t b;
        int        cyc;
        while (stim_q.size() > 0) begin
            b = stim_q.pop_front();
            @(negedge aclk);
            in_valid = 1'b1;
            in_beat  = b;
            cyc      = 0;
            do begin
                @(posedge aclk);
                cyc++;
            end while (!in_ready && (cyc < timeout_cycles));
            if (!in_ready) begin
                other_errs++;
                $display("%s: input beat was not accepted within %0d cycles", name, cyc);
            end
        end
        @(negedge aclk);
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic wait_msgs(input string name, input int n);
        int cyc;
        cyc = 0;
        while ((rx_last - last_mark < n) && (cyc < timeout_cycles)) begin
            @(negedge aclk);
            cyc++;
        end
        if (rx_last - last_mark < n) begin
            other_errs++;
            $display("%s: only %0d of %0d messages came out", name, rx_last - last_mark, n);
        end
    endtask

    // Split captured beats into messages and match them by seq
    task automatic check_output(input string name);
        bft_hdr_t hdr;
        int       pos;
        int       k;
        int       n;
        int       prev_net;
        int       prev_auth;
        pos       = rx_mark;
        prev_net  = -1;
        prev_auth = -1;
        while (pos < rx_q.size()) begin
            hdr = bft_hdr_t'(rx_q[pos].data);
            k   = int'(hdr.seq[7:0]);
            if (!exp_live[k]) begin
                other_errs++;
                $display("%s: unexpected or repeated message with seq %0d", name, hdr.seq);
                while ((pos < rx_q.size()) && !rx_q[pos].last) begin
                    pos++;
                end
                pos++;
            end else begin
                n = exp_len[k];
                if (pos + n > rx_q.size()) begin
                    other_errs++;
                    $display("%s: message seq %0d is cut short", name, hdr.seq);
                    n = rx_q.size() - pos;
                end
                for (int i = 0; i < n; i++) begin
                    check_beat(name, exp_beats[exp_start[k] + i], rx_q[pos + i]);
                end
                // Order within each path follows the send order
                if (hdr.op == op_net) begin
                    if (int'(hdr.seq) <= prev_net) begin
                        other_errs++;
                        $display("%s: network message seq %0d out of order", name, hdr.seq);
                    end
                    prev_net = int'(hdr.seq);
                end else begin
                    if (int'(hdr.seq) <= prev_auth) begin
                        other_errs++;
                        $display("%s: auth message seq %0d out of order", name, hdr.seq);
                    end
                    prev_auth = int'(hdr.seq);
                end
                exp_live[k] = 1'b0;
                pos += n;
            end
        end
        for (int i = 0; i < 256; i++) begin
            if (exp_live[i]) begin
                other_errs++;
                $display("%s: message with seq index %0d never came out", name, i);
            end
        end
    endtask

    task automatic check_stat_counts(input string name);
        check_count({name, " net bytes"}, net_bytes, net_stat.bytes);
        check_count({name, " net msgs"}, net_msgs, net_stat.msgs);
        check_count({name, " auth bytes"}, auth_bytes, auth_stat.bytes);
        check_count({name, " auth msgs"}, auth_msgs, auth_stat.msgs);
    endtask

    task automatic pulse_start(input logic [stat_bits-1:0] n);
        @(negedge aclk);
        ap_start = 1'b1;
        exp_msgs = n;
        @(negedge aclk);
        ap_start = 1'b0;
    endtask

    task automatic clear_expect();
        exp_beats.delete();
        for (int i = 0; i < 256; i++) begin
            exp_live[i] = 1'b0;
        end
        exp_count  = 0;
        net_bytes  = '0;
        net_msgs   = '0;
        auth_bytes = '0;
        auth_msgs  = '0;
        rx_mark    = rx_q.size();
        last_mark  = rx_last;
    endtask

    task automatic begin_test(input logic [stat_bits-1:0] n);
        pulse_start(n);
        clear_expect();
    endtask

    task automatic test_reset_state();
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset ap_done", 1'b0, ap_done);
        check_stat("reset net_stat", '0, net_stat);
        check_stat("reset auth_stat", '0, auth_stat);
        check_count("reset execution_cycles", '0, execution_cycles);
    endtask

    task automatic test_network();
        bft_path_stat_t exp;
        begin_test('0);
        build_msg(op_net, 3);
        drive_all("network");
        wait_msgs("network", exp_count);
        idle(4);
        check_output("network");
        exp.bytes  = net_bytes;
        exp.msgs   = net_msgs;
        exp.stalls = '0;
        check_stat("network net_stat", exp, net_stat);
        check_stat("network auth_stat", '0, auth_stat);
    endtask

    task automatic test_auth();
        bft_path_stat_t exp;
        begin_test('0);
        build_msg(op_auth, 4);
        drive_all("auth");
        wait_msgs("auth", exp_count);
        idle(4);
        check_output("auth");
        exp.bytes  = auth_bytes;
        exp.msgs   = auth_msgs;
        exp.stalls = '0;
        check_stat("auth auth_stat", exp, auth_stat);
        check_stat("auth net_stat", '0, net_stat);
    endtask

    task automatic test_mixed();
        begin_test('0);
        add_random_msgs(24, 1'b1);
        drive_all("mixed");
        wait_msgs("mixed", exp_count);
        idle(4);
        check_output("mixed");
        check_stat_counts("mixed");
    endtask

    // Statistics from the previous test must survive a dropped message
    task automatic test_invalid();
        bft_path_stat_t net_before;
        bft_path_stat_t auth_before;
        clear_expect();
        net_before  = net_stat;
        auth_before = auth_stat;
        build_msg(8'h33, 3);
        drive_all("invalid");
        idle(20);
        check_count("invalid output beats", '0, stat_bits'(rx_q.size() - rx_mark));
        check_stat("invalid net_stat", net_before, net_stat);
        check_stat("invalid auth_stat", auth_before, auth_stat);
    endtask

    task automatic test_backpressure();
        begin_test('0);
        add_random_msgs(24, 1'b1);
        @(posedge aclk);
        bp_on = 1'b1;
        drive_all("backpressure");
        wait_msgs("backpressure", exp_count);
        @(posedge aclk);
        bp_on = 1'b0;
        idle(4);
        check_output("backpressure");
        check_stat_counts("backpressure");
        if ((net_stat.stalls == '0) && (auth_stat.stalls == '0)) begin
            other_errs++;
            $display("backpressure: no stall cycles were counted on either path");
        end
    endtask

    task automatic test_run_ctrl();
        logic [stat_bits-1:0] cycles_done;
        int                   cyc;
        begin_test(stat_bits'(6));
        add_random_msgs(6, 1'b0);
        drive_all("run_ctrl");
        cyc = 0;
        while (!ap_done && (cyc < timeout_cycles)) begin
            @(negedge aclk);
            cyc++;
        end
        if (!ap_done) begin
            other_errs++;
            $display("run_ctrl: ap_done did not rise within %0d cycles", cyc);
        end
        check_output("run_ctrl");
        if (execution_cycles == '0) begin
            other_errs++;
            $display("run_ctrl: execution_cycles is still zero after done");
        end
        cycles_done = execution_cycles;
        idle(10);
        check_count("run_ctrl frozen execution_cycles", cycles_done, execution_cycles);
        check_bit("run_ctrl ap_done held", 1'b1, ap_done);
        // A second start wipes the previous run
        pulse_start(stat_bits'(6));
        check_bit("run_ctrl restart ap_done", 1'b0, ap_done);
        check_count("run_ctrl restart execution_cycles", '0, execution_cycles);
        check_stat("run_ctrl restart net_stat", '0, net_stat);
        check_stat("run_ctrl restart auth_stat", '0, auth_stat);
    endtask

    initial begin
        #(watchdog_ns);
        $display("Simulation watchdog expired before the tests finished");
        $display("Errors: %0d check failures, %0d other failures", check_errs, other_errs + 1);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        aresetn  = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        ap_start = 1'b0;
        exp_msgs = '0;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        test_reset_state();
        test_network();
        test_auth();
        test_mixed();
        test_invalid();
        test_backpressure();
        test_run_ctrl();
        $display("Errors: %0d check failures, %0d other failures", check_errs, other_errs);
        if ((check_errs == 0) && (other_errs == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
source/bft_pkg.sv
source/bft_steer.sv
source/bft_path_profiler.sv
source/bft_auth_tagger.sv
source/bft_merge.sv
source/bft_run_ctrl.sv
source/bft_offload_top.sv
verification/bft_offload_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the offload testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module bft_offload_tb \
    -f sim.f -Mdir obj_dir -o bft_offload_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/bft_offload_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
